/* include/i3c_ccc_codes.svh */
// CCC code values for the supported subset only; broadcast address is the 7-bit form
`ifndef I3C_CCC_CODES_SVH
`define I3C_CCC_CODES_SVH

// Broadcast CCCs
`define I3C_BCAST_ENEC    8'h00
`define I3C_BCAST_DISEC   8'h01
`define I3C_BCAST_SETMWL  8'h09
`define I3C_BCAST_SETMRL  8'h0A
`define I3C_BCAST_ENTHDR0 8'h20
`define I3C_BCAST_RSTACT  8'h2A

// Direct CCCs
`define I3C_DIRECT_ENEC   8'h80
`define I3C_DIRECT_DISEC  8'h81
`define I3C_DIRECT_SETMWL 8'h89
`define I3C_DIRECT_SETMRL 8'h8A
`define I3C_DIRECT_GETMWL 8'h8B
`define I3C_DIRECT_GETMRL 8'h8C
`define I3C_DIRECT_RSTACT 8'h9A

`define I3C_BROADCAST_ADDR 7'h7E

// RSTACT defining bytes accepted by the target
`define I3C_RSTACT_NO_RESET         8'h00
`define I3C_RSTACT_PERIPHERAL_RESET 8'h01

`endif

/* hdl/i3c_ccc_pkg.sv */
// SDR CCC path only; no ENTDAA, HDR traffic, IBI or parity, and unknown CCCs act as NOP
`default_nettype none

package i3c_ccc_pkg;

  // Reset values of the max write and read lengths
  localparam logic [15:0] DEF_MWL = 16'd64;
  localparam logic [15:0] DEF_MRL = 16'd64;

  // Event enable bits are ENINT, ENCR, ENHJ and one reserved bit
  localparam int unsigned EVT_MASK_W = 4;
  localparam logic [EVT_MASK_W-1:0] EVT_RESET = '1;

  // Framer output classes
  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_CODE,
    KIND_ARG,
    KIND_RDREQ,
    KIND_END
  } ccc_kind_e;

  typedef struct packed {
    ccc_kind_e  kind;
    logic [7:0] data;
    // Saturates at 3
    logic [1:0] arg_idx;
    logic       direct;
    // Always set in a broadcast CCC
    logic       targeted;
    logic       rnw;
    logic       valid;
  } ccc_field_t;

  // Decoder actions
  typedef enum logic [3:0] {
    OP_NOP,
    OP_SET_EVENTS,
    OP_CLR_EVENTS,
    OP_RSTACT,
    OP_ENTER_HDR,
    OP_SET_MWL,
    OP_SET_MRL,
    OP_READ_MWL,
    OP_READ_MRL
  } ccc_op_e;

  typedef struct packed {
    ccc_op_e     op;
    logic [15:0] value;
    logic [1:0]  rd_idx;
    logic        valid;
  } ccc_action_t;

endpackage

`default_nettype wire

/* hdl/ccc_framer.sv */
// Expects at most one bus strobe per cycle; direct CCC arguments follow the target address
`timescale 1ns/1ns
`default_nettype none

`include "i3c_ccc_codes.svh"

module ccc_framer (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire  [7:0]              bus_byte_i,
  input  wire                     bus_byte_valid_i,
  input  wire                     bus_start_i,
  input  wire                     bus_stop_i,
  input  wire                     bus_rd_req_i,
  input  wire  [6:0]              static_addr_i,
  output i3c_ccc_pkg::ccc_field_t field_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_CODE,
    ST_ARGS,
    ST_SKIP
  } state_e;

  state_e     state_q, state_d;
  logic       in_ccc_q, in_ccc_d;
  logic       direct_q, direct_d;
  logic       targeted_q, targeted_d;
  logic       rnw_q, rnw_d;
  logic [1:0] arg_idx_q, arg_idx_d;
  logic [1:0] arg_idx_inc;
  logic       addr_is_bcast;
  logic       addr_is_self;

  i3c_ccc_pkg::ccc_field_t field_d;

  assign addr_is_bcast = (bus_byte_i[7:1] == `I3C_BROADCAST_ADDR);
  assign addr_is_self  = (bus_byte_i[7:1] == static_addr_i);
  assign arg_idx_inc   = (arg_idx_q == 2'd3) ? 2'd3 : arg_idx_q + 2'd1;

  always_comb begin
    state_d    = state_q;
    in_ccc_d   = in_ccc_q;
    direct_d   = direct_q;
    targeted_d = targeted_q;
    rnw_d      = rnw_q;
    arg_idx_d  = arg_idx_q;
    field_d    = '0;

    if (bus_stop_i) begin
      if (in_ccc_q) begin
        field_d.kind = i3c_ccc_pkg::KIND_END;
      end
      state_d    = ST_IDLE;
      in_ccc_d   = 1'b0;
      direct_d   = 1'b0;
      targeted_d = 1'b0;
      rnw_d      = 1'b0;
      arg_idx_d  = 2'd0;
    end else if (bus_start_i) begin
      state_d = ST_ADDR;
      // Sr ends a broadcast CCC but keeps a direct one open
      if (in_ccc_q && !direct_q) begin
        field_d.kind = i3c_ccc_pkg::KIND_END;
        in_ccc_d     = 1'b0;
      end
    end else if (bus_byte_valid_i) begin
      case (state_q)
        ST_ADDR: begin
          if (addr_is_bcast && !bus_byte_i[0]) begin
            state_d    = ST_CODE;
            in_ccc_d   = 1'b1;
            direct_d   = 1'b0;
            targeted_d = 1'b1;
            rnw_d      = 1'b0;
            arg_idx_d  = 2'd0;
          end else if (in_ccc_q && !addr_is_bcast) begin
            // Target address inside a direct CCC
            state_d    = ST_ARGS;
            targeted_d = addr_is_self;
            rnw_d      = bus_byte_i[0];
            arg_idx_d  = 2'd0;
          end else begin
            if (in_ccc_q) begin
              field_d.kind = i3c_ccc_pkg::KIND_END;
            end
            state_d  = ST_SKIP;
            in_ccc_d = 1'b0;
          end
        end
        ST_CODE: begin
          field_d.kind = i3c_ccc_pkg::KIND_CODE;
          field_d.data = bus_byte_i;
          direct_d     = bus_byte_i[7];
          // Direct CCC waits for its target address
          targeted_d   = !bus_byte_i[7];
          arg_idx_d    = 2'd0;
          state_d      = ST_ARGS;
        end
        ST_ARGS: begin
          field_d.kind    = i3c_ccc_pkg::KIND_ARG;
          field_d.data    = bus_byte_i;
          field_d.arg_idx = arg_idx_q;
          arg_idx_d       = arg_idx_inc;
        end
        default: ;
      endcase
    end else if (bus_rd_req_i && in_ccc_q && (state_q == ST_ARGS)) begin
      field_d.kind    = i3c_ccc_pkg::KIND_RDREQ;
      field_d.arg_idx = arg_idx_q;
      arg_idx_d       = arg_idx_inc;
    end

    field_d.direct   = direct_d;
    field_d.targeted = targeted_d;
    field_d.rnw      = rnw_d;
    field_d.valid    = (field_d.kind != i3c_ccc_pkg::KIND_NONE);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      in_ccc_q   <= 1'b0;
      direct_q   <= 1'b0;
      targeted_q <= 1'b0;
      rnw_q      <= 1'b0;
      arg_idx_q  <= 2'd0;
      field_o    <= '0;
    end else begin
      state_q    <= state_d;
      in_ccc_q   <= in_ccc_d;
      direct_q   <= direct_d;
      targeted_q <= targeted_d;
      rnw_q      <= rnw_d;
      arg_idx_q  <= arg_idx_d;
      field_o    <= field_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/ccc_decoder.sv */
// One action per completed command or read request; RSTACT accepts defining bytes 00h/01h only
`timescale 1ns/1ns
`default_nettype none

`include "i3c_ccc_codes.svh"

module ccc_decoder (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire  i3c_ccc_pkg::ccc_field_t field_i,
  output i3c_ccc_pkg::ccc_action_t action_o
);

  logic [7:0] code_q;
  logic       code_vld_q;
  logic [7:0] hi_q;
  logic       wr_ok;
  logic       rd_ok;
  logic       is_code;
  logic       is_arg;
  logic       is_end;

  i3c_ccc_pkg::ccc_action_t action_d;

  assign is_code = field_i.valid && (field_i.kind == i3c_ccc_pkg::KIND_CODE);
  assign is_arg  = field_i.valid && (field_i.kind == i3c_ccc_pkg::KIND_ARG);
  assign is_end  = field_i.valid && (field_i.kind == i3c_ccc_pkg::KIND_END);

  // Broadcast frames always arrive targeted with rnw low
  assign wr_ok = code_vld_q && field_i.targeted && !field_i.rnw;
  assign rd_ok = code_vld_q && field_i.targeted && field_i.rnw && field_i.direct;

  always_comb begin
    action_d = '0;

    if (is_code && (field_i.data == `I3C_BCAST_ENTHDR0)) begin
      action_d.op = i3c_ccc_pkg::OP_ENTER_HDR;
    end else if (is_arg && wr_ok) begin
      case (code_q)
        `I3C_BCAST_ENEC, `I3C_DIRECT_ENEC: begin
          if (field_i.arg_idx == 2'd0) begin
            action_d.op    = i3c_ccc_pkg::OP_SET_EVENTS;
            action_d.value = {8'h00, field_i.data};
          end
        end
        `I3C_BCAST_DISEC, `I3C_DIRECT_DISEC: begin
          if (field_i.arg_idx == 2'd0) begin
            action_d.op    = i3c_ccc_pkg::OP_CLR_EVENTS;
            action_d.value = {8'h00, field_i.data};
          end
        end
        `I3C_BCAST_RSTACT, `I3C_DIRECT_RSTACT: begin
          if ((field_i.arg_idx == 2'd0) &&
              ((field_i.data == `I3C_RSTACT_NO_RESET) ||
               (field_i.data == `I3C_RSTACT_PERIPHERAL_RESET))) begin
            action_d.op    = i3c_ccc_pkg::OP_RSTACT;
            action_d.value = {8'h00, field_i.data};
          end
        end
        `I3C_BCAST_SETMWL, `I3C_DIRECT_SETMWL: begin
          if (field_i.arg_idx == 2'd1) begin
            action_d.op    = i3c_ccc_pkg::OP_SET_MWL;
            action_d.value = {hi_q, field_i.data};
          end
        end
        `I3C_BCAST_SETMRL, `I3C_DIRECT_SETMRL: begin
          if (field_i.arg_idx == 2'd1) begin
            action_d.op    = i3c_ccc_pkg::OP_SET_MRL;
            action_d.value = {hi_q, field_i.data};
          end
        end
        default: ;
      endcase
    end else if (field_i.valid && (field_i.kind == i3c_ccc_pkg::KIND_RDREQ) && rd_ok) begin
      // Read index follows the framer count after the address
      action_d.rd_idx = field_i.arg_idx;
      if (code_q == `I3C_DIRECT_GETMWL) begin
        action_d.op = i3c_ccc_pkg::OP_READ_MWL;
      end else if (code_q == `I3C_DIRECT_GETMRL) begin
        action_d.op = i3c_ccc_pkg::OP_READ_MRL;
      end
    end

    action_d.valid = (action_d.op != i3c_ccc_pkg::OP_NOP);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_vld_q <= 1'b0;
      action_o   <= '0;
    end else begin
      if (is_code) begin
        code_vld_q <= 1'b1;
      end else if (is_end) begin
        code_vld_q <= 1'b0;
      end
      action_o <= action_d;
    end
  end

  // Command code and high byte of two-byte arguments
  always_ff @(posedge clk_i) begin
    if (is_code) begin
      code_q <= field_i.data;
    end
    if (is_arg && (field_i.arg_idx == 2'd0)) begin
      hi_q <= field_i.data;
    end
  end

endmodule

`default_nettype wire

/* hdl/ccc_target_state.sv */
// Reset and response outputs are single-cycle pulses; the consumer cannot stall them
`timescale 1ns/1ns
`default_nettype none

module ccc_target_state (
  input  wire                                      clk_i,
  input  wire                                      rst_ni,
  input  wire  i3c_ccc_pkg::ccc_action_t           action_i,
  input  wire                                      hdr_exit_i,
  output logic                                     hdr_mode_o,
  output logic [i3c_ccc_pkg::EVT_MASK_W-1:0]       event_en_o,
  output logic [15:0]                              max_wl_o,
  output logic [15:0]                              max_rl_o,
  output logic [7:0]                               rst_action_o,
  output logic                                     rst_action_valid_o,
  output logic [7:0]                               rsp_byte_o,
  output logic                                     rsp_valid_o
);

  logic        act_set_evt;
  logic        act_clr_evt;
  logic        act_rstact;
  logic        act_hdr;
  logic        act_mwl;
  logic        act_mrl;
  logic        act_read;
  logic        rsp_fire;
  logic [15:0] rd_len;
  logic [7:0]  rd_byte;

  logic [i3c_ccc_pkg::EVT_MASK_W-1:0] evt_arg;

  assign act_set_evt = action_i.valid && (action_i.op == i3c_ccc_pkg::OP_SET_EVENTS);
  assign act_clr_evt = action_i.valid && (action_i.op == i3c_ccc_pkg::OP_CLR_EVENTS);
  assign act_rstact  = action_i.valid && (action_i.op == i3c_ccc_pkg::OP_RSTACT);
  assign act_hdr     = action_i.valid && (action_i.op == i3c_ccc_pkg::OP_ENTER_HDR);
  assign act_mwl     = action_i.valid && (action_i.op == i3c_ccc_pkg::OP_SET_MWL);
  assign act_mrl     = action_i.valid && (action_i.op == i3c_ccc_pkg::OP_SET_MRL);
  assign act_read    = action_i.valid &&
                       ((action_i.op == i3c_ccc_pkg::OP_READ_MWL) ||
                        (action_i.op == i3c_ccc_pkg::OP_READ_MRL));

  assign evt_arg = action_i.value[i3c_ccc_pkg::EVT_MASK_W-1:0];

  // MSB first, nothing past the second byte
  assign rd_len   = (action_i.op == i3c_ccc_pkg::OP_READ_MRL) ? max_rl_o : max_wl_o;
  assign rd_byte  = action_i.rd_idx[0] ? rd_len[7:0] : rd_len[15:8];
  assign rsp_fire = act_read && !action_i.rd_idx[1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_mode_o         <= 1'b0;
      event_en_o         <= i3c_ccc_pkg::EVT_RESET;
      max_wl_o           <= i3c_ccc_pkg::DEF_MWL;
      max_rl_o           <= i3c_ccc_pkg::DEF_MRL;
      rst_action_valid_o <= 1'b0;
      rsp_valid_o        <= 1'b0;
    end else begin
      // Entry wins over a coincident exit pulse
      if (act_hdr) begin
        hdr_mode_o <= 1'b1;
      end else if (hdr_exit_i) begin
        hdr_mode_o <= 1'b0;
      end

      if (act_set_evt) begin
        event_en_o <= event_en_o | evt_arg;
      end else if (act_clr_evt) begin
        event_en_o <= event_en_o & ~evt_arg;
      end

      if (act_mwl) begin
        max_wl_o <= action_i.value;
      end
      if (act_mrl) begin
        max_rl_o <= action_i.value;
      end

      rst_action_valid_o <= act_rstact;
      rsp_valid_o        <= rsp_fire;
    end
  end

  // Pulse payloads, qualified by their valid flags
  always_ff @(posedge clk_i) begin
    if (act_rstact) begin
      rst_action_o <= action_i.value[7:0];
    end
    if (rsp_fire) begin
      rsp_byte_o <= rd_byte;
    end
  end

endmodule

`default_nettype wire

/* hdl/i3c_ccc_top.sv */
// Bus strobes reach the outputs three cycles later; there is no back-pressure anywhere
`timescale 1ns/1ns
`default_nettype none

module i3c_ccc_top (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  wire  [7:0]                         bus_byte_i,
  input  wire                                bus_byte_valid_i,
  input  wire                                bus_start_i,
  input  wire                                bus_stop_i,
  input  wire                                bus_rd_req_i,
  input  wire                                hdr_exit_i,
  input  wire  [6:0]                         static_addr_i,
  output logic                               hdr_mode_o,
  output logic [i3c_ccc_pkg::EVT_MASK_W-1:0] event_en_o,
  output logic [15:0]                        max_wl_o,
  output logic [15:0]                        max_rl_o,
  output logic [7:0]                         rst_action_o,
  output logic                               rst_action_valid_o,
  output logic [7:0]                         rsp_byte_o,
  output logic                               rsp_valid_o
);

  i3c_ccc_pkg::ccc_field_t  field;
  i3c_ccc_pkg::ccc_action_t action;

  ccc_framer u_framer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_byte_i       (bus_byte_i),
    .bus_byte_valid_i (bus_byte_valid_i),
    .bus_start_i      (bus_start_i),
    .bus_stop_i       (bus_stop_i),
    .bus_rd_req_i     (bus_rd_req_i),
    .static_addr_i    (static_addr_i),
    .field_o          (field)
  );

  ccc_decoder u_decoder (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .field_i  (field),
    .action_o (action)
  );

  ccc_target_state u_state (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .action_i           (action),
    .hdr_exit_i         (hdr_exit_i),
    .hdr_mode_o         (hdr_mode_o),
    .event_en_o         (event_en_o),
    .max_wl_o           (max_wl_o),
    .max_rl_o           (max_rl_o),
    .rst_action_o       (rst_action_o),
    .rst_action_valid_o (rst_action_valid_o),
    .rsp_byte_o         (rsp_byte_o),
    .rsp_valid_o        (rsp_valid_o)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// Free-running 8 ns clock; reset held low for the first two clock cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_NS = 4;

  // Release lands on the falling edge after the second rising edge
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    #(4 * HALF_NS);
    rst_no = 1'b1;
  end

  always #(HALF_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* bench/i3c_ccc_tb.sv */
// Static address fixed at 2Ah; outputs are compared after the fixed 3-cycle path latency
`timescale 1ns/1ns
`default_nettype none

`include "i3c_ccc_codes.svh"

module i3c_ccc_tb;

  localparam logic [6:0] SELF_ADDR = 7'h2A;
  localparam int STB_START = 0;
  localparam int STB_STOP  = 1;
  localparam int STB_BYTE  = 2;
  localparam int STB_READ  = 3;
  localparam int STB_IDLE  = 4;
  // Test lengths in cycles with at most 10 strobes per frame and 5 per state check
  localparam int T_RESET   = 10;
  localparam int T_LENGTHS = 2 * (4 * 10 + 2 * 5);
  localparam int T_OTHER   = 6 * 10 + 5;
  localparam int T_RSTACT  = 3 * (2 * 10 + 5);
  localparam int T_EVENTS  = 8 * (10 + 5);
  localparam int T_HDR     = 3 * 10 + 4 * 5 + 14;
  localparam int WATCHDOG_NS =
    (T_RESET + T_LENGTHS + T_OTHER + T_RSTACT + T_EVENTS + T_HDR + 100) * 8;

  logic        clk;
  logic        rst_n;
  logic [7:0]  bus_byte;
  logic        bus_byte_valid;
  logic        bus_start;
  logic        bus_stop;
  logic        bus_rd_req;
  logic        hdr_exit;
  logic [6:0]  static_addr;
  logic        hdr_mode;
  logic [i3c_ccc_pkg::EVT_MASK_W-1:0] event_en;
  logic [15:0] max_wl;
  logic [15:0] max_rl;
  logic [7:0]  rst_action;
  logic        rst_action_valid;
  logic [7:0]  rsp_byte;
  logic        rsp_valid;

  // Reference model
  logic        exp_hdr;
  logic [i3c_ccc_pkg::EVT_MASK_W-1:0] exp_evt;
  logic [15:0] exp_mwl;
  logic [15:0] exp_mrl;
  logic [7:0]  exp_rsp[$];
  logic [7:0]  exp_rst[$];
  logic [7:0]  want_rsp;
  logic [7:0]  want_rst;

  logic [31:0] lfsr_q;
  logic [15:0] val;
  logic [6:0]  other;
  logic        pick;
  string       test_name;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  i3c_ccc_top u_i3c_ccc_top (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .bus_byte_i         (bus_byte),
    .bus_byte_valid_i   (bus_byte_valid),
    .bus_start_i        (bus_start),
    .bus_stop_i         (bus_stop),
    .bus_rd_req_i       (bus_rd_req),
    .hdr_exit_i         (hdr_exit),
    .static_addr_i      (static_addr),
    .hdr_mode_o         (hdr_mode),
    .event_en_o         (event_en),
    .max_wl_o           (max_wl),
    .max_rl_o           (max_rl),
    .rst_action_o       (rst_action),
    .rst_action_valid_o (rst_action_valid),
    .rsp_byte_o         (rsp_byte),
    .rsp_valid_o        (rsp_valid)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic report_value(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
    $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
    $display("sim failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    $display("sim failed");
    $fatal(1, "check failed");
  endtask

  task automatic drive_strobe(input int kind, input logic [7:0] data);
    @(negedge clk);
    bus_start      = (kind == STB_START);
    bus_stop       = (kind == STB_STOP);
    bus_byte_valid = (kind == STB_BYTE);
    bus_rd_req     = (kind == STB_READ);
    bus_byte       = data;
  endtask

  task automatic model_write(input logic [7:0] code, input logic hit, input int nargs,
                             input logic [15:0] args);
    logic [7:0] first;
    first = (nargs == 2) ? args[15:8] : args[7:0];
    if (code == `I3C_BCAST_ENTHDR0) begin
      exp_hdr = 1'b1;
    end else if (hit && (nargs != 0)) begin
      case (code)
        `I3C_BCAST_ENEC, `I3C_DIRECT_ENEC:
          exp_evt = exp_evt | first[i3c_ccc_pkg::EVT_MASK_W-1:0];
        `I3C_BCAST_DISEC, `I3C_DIRECT_DISEC:
          exp_evt = exp_evt & ~first[i3c_ccc_pkg::EVT_MASK_W-1:0];
        `I3C_BCAST_RSTACT, `I3C_DIRECT_RSTACT: begin
          if (first <= `I3C_RSTACT_PERIPHERAL_RESET) begin
            exp_rst.push_back(first);
          end
        end
        `I3C_BCAST_SETMWL, `I3C_DIRECT_SETMWL: begin
          if (nargs == 2) begin
            exp_mwl = args;
          end
        end
        `I3C_BCAST_SETMRL, `I3C_DIRECT_SETMRL: begin
          if (nargs == 2) begin
            exp_mrl = args;
          end
        end
        default: ;
      endcase
    end
  endtask

  // GET returns MSB then LSB and nothing after that
  task automatic model_read(input logic [7:0] code, input logic hit, input int nreq);
    logic [15:0] len;
    len = (code == `I3C_DIRECT_GETMRL) ? exp_mrl : exp_mwl;
    for (int i = 0; (i < nreq) && (i < 2) && hit; i++) begin
      exp_rsp.push_back((i == 0) ? len[15:8] : len[7:0]);
    end
  endtask

  task automatic send_args(input int nargs, input logic [15:0] args);
    for (int i = 0; i < nargs; i++) begin
      drive_strobe(STB_BYTE, (nargs - i == 2) ? args[15:8] : args[7:0]);
    end
  endtask

  task automatic bcast_ccc(input logic [7:0] code, input int nargs, input logic [15:0] args);
    model_write(code, 1'b1, nargs, args);
    drive_strobe(STB_START, 8'h00);
    drive_strobe(STB_BYTE, {`I3C_BROADCAST_ADDR, 1'b0});
    drive_strobe(STB_BYTE, code);
    send_args(nargs, args);
    drive_strobe(STB_STOP, 8'h00);
    drive_strobe(STB_IDLE, 8'h00);
  endtask

  task automatic direct_write(input logic [7:0] code, input logic [6:0] addr, input int nargs,
                              input logic [15:0] args);
    model_write(code, addr == SELF_ADDR, nargs, args);
    drive_strobe(STB_START, 8'h00);
    drive_strobe(STB_BYTE, {`I3C_BROADCAST_ADDR, 1'b0});
    drive_strobe(STB_BYTE, code);
    drive_strobe(STB_START, 8'h00);
    drive_strobe(STB_BYTE, {addr, 1'b0});
    send_args(nargs, args);
    drive_strobe(STB_STOP, 8'h00);
    drive_strobe(STB_IDLE, 8'h00);
  endtask

  task automatic direct_read(input logic [7:0] code, input logic [6:0] addr, input int nreq);
    model_read(code, addr == SELF_ADDR, nreq);
    drive_strobe(STB_START, 8'h00);
    drive_strobe(STB_BYTE, {`I3C_BROADCAST_ADDR, 1'b0});
    drive_strobe(STB_BYTE, code);
    drive_strobe(STB_START, 8'h00);
    drive_strobe(STB_BYTE, {addr, 1'b1});
    repeat (nreq) drive_strobe(STB_READ, 8'h00);
    drive_strobe(STB_STOP, 8'h00);
    drive_strobe(STB_IDLE, 8'h00);
  endtask

  // Non-CCC frame with two data bytes after the address
  task automatic plain_frame(input logic [7:0] addr_byte, input logic [15:0] data);
    drive_strobe(STB_START, 8'h00);
    drive_strobe(STB_BYTE, addr_byte);
    send_args(2, data);
    drive_strobe(STB_STOP, 8'h00);
    drive_strobe(STB_IDLE, 8'h00);
  endtask

  task automatic check_state();
    repeat (5) @(negedge clk);
    assert (hdr_mode == exp_hdr) else report_value("hdr_mode_o", 16'(exp_hdr), 16'(hdr_mode));
    assert (event_en == exp_evt) else report_value("event_en_o", 16'(exp_evt), 16'(event_en));
    assert (max_wl == exp_mwl) else report_value("max_wl_o", exp_mwl, max_wl);
    assert (max_rl == exp_mrl) else report_value("max_rl_o", exp_mrl, max_rl);
    assert (exp_rsp.size() == 0) else report_failure("an expected response byte never came");
    assert (exp_rst.size() == 0) else report_failure("an expected reset action never came");
  endtask

  // Pulses are matched in order against the model queues
  always @(negedge clk) begin
    if (rsp_valid) begin
      assert (exp_rsp.size() != 0) begin
        want_rsp = exp_rsp.pop_front();
        assert (rsp_byte == want_rsp) else
          report_value("rsp_byte_o", 16'(want_rsp), 16'(rsp_byte));
      end else begin
        report_failure("rsp_valid_o pulsed with no response expected");
      end
    end
    if (rst_action_valid) begin
      assert (exp_rst.size() != 0) begin
        want_rst = exp_rst.pop_front();
        assert (rst_action == want_rst) else
          report_value("rst_action_o", 16'(want_rst), 16'(rst_action));
      end else begin
        report_failure("rst_action_valid_o pulsed with no reset action expected");
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin
    lfsr_q         = 32'h5b4059fe;
    bus_byte       = 8'h00;
    bus_byte_valid = 1'b0;
    bus_start      = 1'b0;
    bus_stop       = 1'b0;
    bus_rd_req     = 1'b0;
    hdr_exit       = 1'b0;
    static_addr    = SELF_ADDR;
    exp_hdr        = 1'b0;
    exp_evt        = '1;
    exp_mwl        = i3c_ccc_pkg::DEF_MWL;
    exp_mrl        = i3c_ccc_pkg::DEF_MRL;
    @(posedge rst_n);

    test_name = "reset_values";
    check_state();

    test_name = "set_get_lengths";
    for (int i = 0; i < 2; i++) begin
      bcast_ccc((i == 0) ? `I3C_BCAST_SETMWL : `I3C_BCAST_SETMRL, 2, 16'(rand_bits(16)));
      direct_write((i == 0) ? `I3C_DIRECT_SETMRL : `I3C_DIRECT_SETMWL, SELF_ADDR, 2,
                   16'(rand_bits(16)));
      check_state();
      direct_read(`I3C_DIRECT_GETMWL, SELF_ADDR, 3);
      direct_read(`I3C_DIRECT_GETMRL, SELF_ADDR, 3);
      check_state();
    end

    test_name = "other_target";
    other = 7'(rand_bits(7));
    while ((other == SELF_ADDR) || (other == `I3C_BROADCAST_ADDR)) begin
      other = 7'(rand_bits(7));
    end
    direct_write(`I3C_DIRECT_SETMWL, other, 2, 16'(rand_bits(16)));
    direct_write(`I3C_DIRECT_SETMRL, other, 2, 16'(rand_bits(16)));
    direct_write(`I3C_DIRECT_DISEC, other, 1, 16'h00ff);
    direct_write(`I3C_DIRECT_RSTACT, other, 1, 16'h0001);
    direct_read(`I3C_DIRECT_GETMWL, other, 2);
    direct_read(`I3C_DIRECT_GETMRL, other, 2);
    check_state();

    test_name = "rstact";
    for (int d = 0; d < 3; d++) begin
      val = (d < 2) ? 16'(d) : {8'h00, 8'(rand_bits(8)) | 8'h02};
      bcast_ccc(`I3C_BCAST_RSTACT, 1, val);
      direct_write(`I3C_DIRECT_RSTACT, SELF_ADDR, 1, val);
      check_state();
    end

    test_name = "event_enable";
    for (int i = 0; i < 8; i++) begin
      val  = 16'(rand_bits(8));
      pick = (rand_bits(1) != 32'd0);
      if (pick) begin
        bcast_ccc(i[0] ? `I3C_BCAST_DISEC : `I3C_BCAST_ENEC, 1, val);
      end else begin
        direct_write(i[0] ? `I3C_DIRECT_DISEC : `I3C_DIRECT_ENEC, SELF_ADDR, 1, val);
      end
      check_state();
    end

    test_name = "hdr_mode";
    plain_frame({SELF_ADDR, 1'b0}, {`I3C_BCAST_ENTHDR0, `I3C_BCAST_SETMWL});
    plain_frame({`I3C_BROADCAST_ADDR, 1'b1}, {`I3C_BCAST_ENTHDR0, 8'h00});
    check_state();
    bcast_ccc(`I3C_BCAST_ENTHDR0, 0, 16'h0000);
    check_state();
    repeat (10) @(negedge clk);
    check_state();
    @(negedge clk);
    hdr_exit = 1'b1;
    @(negedge clk);
    hdr_exit = 1'b0;
    exp_hdr  = 1'b0;
    check_state();

    // Idle tail so that a stray late pulse still reaches the monitor
    repeat (4) @(negedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* i3c_ccc_top.f */
+incdir+include
hdl/i3c_ccc_pkg.sv
hdl/ccc_framer.sv
hdl/ccc_decoder.sv
hdl/ccc_target_state.sv
hdl/i3c_ccc_top.sv
bench/tb_clock_gen.sv
bench/i3c_ccc_tb.sv

/* Makefile */
TOP   := i3c_ccc_tb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f i3c_ccc_top.f \
		--top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
